// ==== g709_fec.f ====
+incdir+test
rtl/g709_pkg.sv
rtl/rs_enc.sv
rtl/g709_enc.sv
test/g709_enc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the g709 encoder testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module g709_enc_tb -f g709_fec.f

# the pipe keeps the log even when the run stops early
./obj_dir/Vg709_enc_tb | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
  echo "simulation ok"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// ==== test/g709_ref.svh ====
`ifndef G709_REF_SVH
`define G709_REF_SVH

//------------------------------
// random source
//------------------------------

// 32-bit lcg, numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

//------------------------------
// reference field math
//------------------------------

// carry-less product first, then fold the high bits
function automatic gf_t gf_mul_bits(input gf_t a, input gf_t b);
  logic [15:0] prod;
  prod = '0;
  for (int i = 0; i < cM; i++) begin
    if (b[i]) begin
      prod ^= {8'h00, a} << i;
    end
  end
  // bit 14 is the highest term a product can reach
  for (int i = 2*cM-2; i >= cM; i--) begin
    if (prod[i]) begin
      prod ^= 16'(cIRRPOL) << (i - cM);
    end
  end
  return prod[cM-1:0];
endfunction

// check byte k in bits 8k+7..8k, k = 0 leaves the encoder first
typedef logic [cCHECK*cM-1:0] par_vec_t;

// one lane, long division of m(x)*x^16 by g(x)
function automatic par_vec_t ref_parity(input gf_t msg [cK]);
  gf_t      gen [cCHECK+1];
  gf_t      root;
  gf_t      step;
  gf_t      rem [cN];
  gf_t      coef;
  par_vec_t res;
  root = 8'h01;
  step = 8'h01;
  for (int i = 0; i < cGENSTART; i++) begin
    root = gf_mul_bits(root, 8'h02);
  end
  for (int i = 0; i < cROOTSPACE; i++) begin
    step = gf_mul_bits(step, 8'h02);
  end
  // g(x), ascending powers, one (x + root) factor per pass
  for (int i = 0; i <= cCHECK; i++) begin
    gen[i] = '0;
  end
  gen[0] = 8'h01;
  for (int r = 0; r < cCHECK; r++) begin
    for (int i = r + 1; i > 0; i--) begin
      gen[i] = gen[i-1] ^ gf_mul_bits(gen[i], root);
    end
    gen[0] = gf_mul_bits(gen[0], root);
    root   = gf_mul_bits(root, step);
  end
  // index 0 holds x^254, message on top, zeros below
  for (int i = 0; i < cN; i++) begin
    rem[i] = (i < cK) ? msg[i] : '0;
  end
  for (int i = 0; i < cK; i++) begin
    coef = rem[i];
    // monic g(x) cancels the leading term
    for (int j = 0; j <= cCHECK; j++) begin
      rem[i+j] ^= gf_mul_bits(coef, gen[cCHECK-j]);
    end
  end
  // x^15 coefficient goes out first
  for (int k = 0; k < cCHECK; k++) begin
    res[cM*k +: cM] = rem[cK+k];
  end
  return res;
endfunction

`endif

// ==== test/g709_enc_tb.sv ====
`timescale 1ns/1ns

module g709_enc_tb;

  import g709_pkg::*;

  `include "g709_ref.svh"

  // dut side
  logic  iclk;
  logic  rst;
  logic  clkena;
  logic  in_val;
  logic  in_sop;
  word_t in_dat;
  logic  out_val;
  logic  out_sop;
  word_t out_dat;

  // expected output stream with one entry per coded word
  word_t exp_dat_q [$];
  logic  exp_sop_q [$];

  logic [31:0] seed;
  int          err_val;
  int          err_seq;
  int          n_checked;
  int          wait_cnt;
  // random idle and frozen cycles ahead of each word
  logic        use_gaps;
  logic        use_stalls;

  g709_enc UUT (
    .iclk    (iclk),
    .rst     (rst),
    .clkena  (clkena),
    .in_val  (in_val),
    .in_sop  (in_sop),
    .in_dat  (in_dat),
    .out_val (out_val),
    .out_sop (out_sop),
    .out_dat (out_dat)
  );

  initial iclk = 1'b0;
  always #2 iclk = ~iclk;

  //------------------------------
  // helpers
  //------------------------------

  function automatic logic [15:0] rand16();
    seed = lcg_next(seed);
    return seed[31:16];
  endfunction

  function automatic word_t rand_word();
    word_t w;
    for (int i = 0; i < 8; i++) begin
      w[16*i +: 16] = rand16();
    end
    return w;
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      err_val++;
      $display("FAILED @%0t %s exp %h act %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_val++;
      $display("FAILED @%0t %s exp %b act %b", $time, name, exp, act);
    end
  endtask

  task automatic drive_idle();
    @(posedge iclk);
    clkena <= 1'b1;
    in_val <= 1'b0;
    in_sop <= 1'b0;
    in_dat <= rand_word();
  endtask

  // one valid word after an optional run of gap or stall cycles
  task automatic send_word(input word_t w, input logic sop);
    int          n;
    logic [15:0] r;
    if (use_gaps && (rand16() % 4 == 0)) begin
      n = 1 + rand16() % 3;
      repeat (n) drive_idle();
    end
    if (use_stalls && (rand16() % 4 == 0)) begin
      n = 1 + rand16() % 3;
      // junk on every input that the dut must ignore
      repeat (n) begin
        @(posedge iclk);
        r = rand16();
        clkena <= 1'b0;
        in_val <= r[0];
        in_sop <= r[1];
        in_dat <= rand_word();
      end
    end
    @(posedge iclk);
    clkena <= 1'b1;
    in_val <= 1'b1;
    in_sop <= sop;
    in_dat <= w;
  endtask

  // a cut below cN stops the frame early so the next one needs sop
  task automatic send_frame(input logic sop, input int cut, input logic check_lat);
    word_t    msg_w    [cK];
    word_t    par_w    [cCHECK];
    gf_t      one_lane [cK];
    par_vec_t pv;
    word_t    w;
    logic     s;
    for (int p = 0; p < cut; p++) begin
      w = rand_word();
      s = sop && (p == 0);
      if (p < cK) begin
        msg_w[p] = w;
        exp_dat_q.push_back(w);
      end
      else begin
        // check bytes lane by lane once the message is complete
        if (p == cK) begin
          for (int l = 0; l < cLANES; l++) begin
            for (int i = 0; i < cK; i++) begin
              one_lane[i] = msg_w[i][cM*l +: cM];
            end
            pv = ref_parity(one_lane);
            for (int k = 0; k < cCHECK; k++) begin
              par_w[k][cM*l +: cM] = pv[cM*k +: cM];
            end
          end
        end
        exp_dat_q.push_back(par_w[p - cK]);
      end
      exp_sop_q.push_back(s);
      send_word(w, s);
      // word 0 due exactly one cycle after it was taken
      if (check_lat && p == 1) begin
        compare_bit("out_val", 1'b0, out_val);
      end
      if (check_lat && p == 2) begin
        compare_bit("out_val", 1'b1, out_val);
        compare_bit("out_sop", 1'b1, out_sop);
      end
    end
  endtask

  //------------------------------
  // output checker
  //------------------------------

  // sampled on enabled edges only so each coded word is seen once
  always @(posedge iclk) begin
    if (clkena && !rst) begin
      if (out_val === 1'b1) begin
        if (exp_dat_q.size() == 0) begin
          err_seq++;
          $display("output word at %0t with nothing left to expect", $time);
        end
        else begin
          compare_word("out_dat", exp_dat_q.pop_front(), out_dat);
          compare_bit("out_sop", exp_sop_q.pop_front(), out_sop);
          n_checked++;
        end
      end
      else if (out_val !== 1'b0) begin
        err_seq++;
        $display("out_val is unknown at %0t", $time);
      end
    end
  end

  //------------------------------
  // stimulus
  //------------------------------

  initial begin
    seed       = 32'ha4a6;
    err_val    = 0;
    err_seq    = 0;
    n_checked  = 0;
    use_gaps   = 1'b0;
    use_stalls = 1'b0;
    rst        = 1'b1;
    clkena     = 1'b1;
    in_val     = 1'b0;
    in_sop     = 1'b0;
    in_dat     = '0;
    // outputs quiet through reset
    for (int i = 0; i < 16; i++) begin
      @(posedge iclk);
      if (i > 0) begin
        compare_bit("out_val", 1'b0, out_val);
      end
    end
    rst <= 1'b0;
    repeat (8) drive_idle();
    // single clean frame with the latency probe
    send_frame(1'b1, cN, 1'b1);
    // back to back frames where the position wraps by itself
    send_frame(1'b0, cN, 1'b0);
    use_gaps = 1'b1;
    send_frame(1'b0, cN, 1'b0);
    use_gaps   = 1'b0;
    use_stalls = 1'b1;
    send_frame(1'b0, cN, 1'b0);
    // restart inside the message part
    use_gaps = 1'b1;
    send_frame(1'b0, 1 + rand16() % 238, 1'b0);
    send_frame(1'b1, cN, 1'b0);
    send_frame(1'b0, cN, 1'b0);
    // restart inside the parity slots
    send_frame(1'b0, cK + rand16() % cCHECK, 1'b0);
    send_frame(1'b1, cN, 1'b0);
    // drain
    wait_cnt = 0;
    while (exp_dat_q.size() != 0 && wait_cnt < 1000) begin
      drive_idle();
      wait_cnt++;
    end
    if (exp_dat_q.size() != 0) begin
      err_seq++;
      $display("timeout, %0d expected words never came out", exp_dat_q.size());
    end
    // anything extra shows up here
    repeat (8) drive_idle();
    $display("errors: %0d value, %0d sequence, %0d words checked",
             err_val, err_seq, n_checked);
    if (err_val == 0 && err_seq == 0) begin
      $display("TB PASSED");
    end
    else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/g709_enc.sv ====
`timescale 1ns/1ns

module g709_enc (
  input  logic            iclk,
  input  logic            rst,
  input  logic            clkena,
  // interleaved input words
  input  logic            in_val,
  input  logic            in_sop,
  input  g709_pkg::word_t in_dat,
  // coded output words
  output logic            out_val,
  output logic            out_sop,
  output g709_pkg::word_t out_dat
);

  import g709_pkg::*;

  //------------------------------
  // declarations
  //------------------------------

  // position of the word now at the input
  cnt_t cnt_value;
  // current word is 238, last message byte
  logic cnt_eop;
  // current word is 254, last parity slot
  logic cnt_eof;

  // flags as handed to the lanes, masked by sop
  logic lane_eop;
  logic lane_eof;

  // per lane bytes
  gf_t  lane_dat     [cLANES];
  gf_t  lane_enc_dat [cLANES];

  // lane strobes, all lanes run in lockstep
  logic lane_enc_sop [cLANES];
  logic lane_enc_val [cLANES];

  //------------------------------
  // frame counter
  //------------------------------

  // flags computed one word ahead so eop/eof line up with the
  // word they belong to
  always_ff @(posedge iclk) begin
    if (rst) begin
      cnt_value <= '0;
      cnt_eop   <= 1'b0;
      cnt_eof   <= 1'b0;
    end
    else if (clkena && in_val) begin
      if (in_sop) begin
        // word 0 now, word 1 next
        cnt_value <= cnt_t'(1);
        cnt_eop   <= 1'b0;
        cnt_eof   <= 1'b0;
      end
      else begin
        // wrap after the last parity slot, no sop needed
        cnt_value <= cnt_eof ? '0 : (cnt_value + 1'b1);
        // next word is 238
        cnt_eop   <= (cnt_value == cnt_t'(cK - 2));
        // next word is 254
        cnt_eof   <= (cnt_value == cnt_t'(cN - 2));
      end
    end
  end

  // a restart never ends a frame
  assign lane_eop = cnt_eop & ~in_sop;
  assign lane_eof = cnt_eof & ~in_sop;

  //------------------------------
  // lane split
  //------------------------------

  always_comb begin
    for (int i = 0; i < cLANES; i++) begin
      lane_dat[i] = in_dat[cM*i +: cM];
    end
  end

  //------------------------------
  // encoder array
  //------------------------------

  generate
    for (genvar g = 0; g < cLANES; g++) begin : enc_lane_gen
      rs_enc enc (
        .iclk    (iclk),
        .rst     (rst),
        .clkena  (clkena),
        // shared framing
        .sop     (in_sop),
        .val     (in_val),
        .eop     (lane_eop),
        .eof     (lane_eof),
        .dat     (lane_dat[g]),
        // lane result
        .enc_sop (lane_enc_sop[g]),
        .enc_val (lane_enc_val[g]),
        // not needed at this level
        .enc_eop (),
        .enc_dat (lane_enc_dat[g])
      );
    end
  endgenerate

  //------------------------------
  // output assembly
  //------------------------------

  always_comb begin
    // lane 0 speaks for all
    out_val = lane_enc_val[0];
    out_sop = lane_enc_sop[0];
    // same byte order as the input word
    for (int i = 0; i < cLANES; i++) begin
      out_dat[cM*i +: cM] = lane_enc_dat[i];
    end
  end

endmodule

// ==== rtl/rs_enc.sv ====
`timescale 1ns/1ns

module rs_enc (
  input  logic          iclk,
  input  logic          rst,
  input  logic          clkena,
  // input byte stream
  input  logic          sop,
  input  logic          val,
  input  logic          eop,
  input  logic          eof,
  input  g709_pkg::gf_t dat,
  // coded byte stream
  output logic          enc_sop,
  output logic          enc_val,
  output logic          enc_eop,
  output g709_pkg::gf_t enc_dat
);

  import g709_pkg::*;

  //------------------------------
  // declarations
  //------------------------------

  // encoder phase
  enc_state_t state;

  // remainder register, par[cCHECK-1] is the top (x^15) term
  gf_t par     [cCHECK];
  // remainder as seen by the current byte
  gf_t par_cur [cCHECK];

  // lfsr feedback and its products with g(x)
  gf_t fb;
  gf_t fb_mul  [cCHECK];

  // byte goes through the division path
  logic msg_mode;

  //------------------------------
  // generator taps
  //------------------------------

  // constant multipliers, one per remainder stage
  // g(x) is monic so the x^16 term needs no tap
  generate
    for (genvar gi = 0; gi < cCHECK; gi++) begin : tap_gen
      localparam gf_t cCOEF = gen_coef(gi);
      assign fb_mul[gi] = gf_mul(fb, cCOEF);
    end
  endgenerate

  //------------------------------
  // feedback
  //------------------------------

  always_comb begin
    // sop always opens a new codeword, even in parity phase
    msg_mode = sop | (state == st_msg);
    // drop the old remainder on sop
    for (int i = 0; i < cCHECK; i++) begin
      par_cur[i] = sop ? '0 : par[i];
    end
    // message byte plus top remainder term
    fb = dat ^ par_cur[cCHECK-1];
  end

  //------------------------------
  // control
  //------------------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      state   <= st_msg;
      enc_val <= 1'b0;
      enc_sop <= 1'b0;
      enc_eop <= 1'b0;
    end
    else if (clkena) begin
      // strobes follow the input by one cycle
      enc_val <= val;
      enc_sop <= val & sop;
      enc_eop <= val & eop;
      if (val) begin
        if (msg_mode) begin
          // last message byte -> parity slots follow
          state <= eop ? st_par : st_msg;
        end
        else if (eof) begin
          // last parity slot done
          state <= st_msg;
        end
      end
    end
  end

  //------------------------------
  // datapath
  //------------------------------

  // payload registers, no reset
  always_ff @(posedge iclk) begin
    if (clkena && val) begin
      if (msg_mode) begin
        // systematic part passes through
        enc_dat <= dat;
        // divide by g(x) one symbol per byte
        par[0] <= fb_mul[0];
        for (int i = 1; i < cCHECK; i++) begin
          par[i] <= par_cur[i-1] ^ fb_mul[i];
        end
      end
      else begin
        // parity slot, input content ignored
        enc_dat <= par[cCHECK-1];
        // shift up, zero in at the bottom
        par[0] <= '0;
        for (int i = 1; i < cCHECK; i++) begin
          par[i] <= par[i-1];
        end
      end
    end
  end

endmodule

// ==== rtl/g709_pkg.sv ====
package g709_pkg;

  //------------------------------
  // code constants
  //------------------------------

  // RS(255,239) over GF(2^8)
  localparam int cN         = 255;
  localparam int cCHECK     = 16;
  localparam int cK         = cN - cCHECK;
  localparam int cM         = 8;
  // x^8 + x^4 + x^3 + x^2 + 1
  localparam int cIRRPOL    = 285;
  // generator roots alpha^0 .. alpha^15
  localparam int cGENSTART  = 0;
  localparam int cROOTSPACE = 1;
  // byte interleave depth
  localparam int cLANES     = 16;
  localparam int cCNT_W     = 8;

  //------------------------------
  // shared types
  //------------------------------

  typedef logic [cM-1 : 0]        gf_t;
  // lane i sits in bits 8i+7 .. 8i
  typedef logic [cLANES*cM-1 : 0] word_t;
  typedef logic [cCNT_W-1 : 0]    cnt_t;

  // message accumulate / parity shift-out
  typedef enum logic {
    st_msg,
    st_par
  } enc_state_t;

  //------------------------------
  // field arithmetic
  //------------------------------

  // shift-and-add multiply, reduced by the field polynomial
  function automatic gf_t gf_mul(input gf_t a, input gf_t b);
    gf_t acc;
    gf_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < cM; i++) begin
      if (b[i]) begin
        acc ^= sh;
      end
      // multiply by alpha, fold x^8 back in
      sh = sh[cM-1] ? ((sh << 1) ^ gf_t'(cIRRPOL)) : (sh << 1);
    end
    return acc;
  endfunction

  // alpha^e, exponent taken modulo the group order
  function automatic gf_t gf_pow(input int e);
    gf_t r;
    r = gf_t'(1);
    for (int i = 0; i < (e % cN); i++) begin
      r = gf_mul(r, gf_t'(2));
    end
    return r;
  endfunction

  // coefficient j of g(x) = prod (x + alpha^(start + r*space)), monic
  function automatic gf_t gen_coef(input int j);
    gf_t g [cCHECK+1];
    gf_t root;
    for (int i = 0; i <= cCHECK; i++) begin
      g[i] = '0;
    end
    g[0] = gf_t'(1);
    for (int r = 0; r < cCHECK; r++) begin
      root = gf_pow(cGENSTART + r*cROOTSPACE);
      // multiply running product by (x + root), high terms first
      for (int i = cCHECK; i > 0; i--) begin
        g[i] = g[i-1] ^ gf_mul(g[i], root);
      end
      g[0] = gf_mul(g[0], root);
    end
    return g[j];
  endfunction

endpackage
